/* Bender.yml */
package:
  name: id_stage

sources:
  - files:
      - common/id_pkg.sv
      - common/decode_result_if.sv
      - source/id_front.sv
      - decoder/decoder_3r.sv
      - decoder/decoder_2ri8.sv
      - decoder/decoder_2ri12.sv
      - decoder/id_decoder.sv
      - source/gpr_file.sv
      - source/id_issue.sv
      - source/id_stage.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_id_stage.sv

/* common/decode_result_if.sv */
`default_nettype none

interface decode_result_if;

    logic                              valid;
    // bit 0 for rj, bit 1 for rk
    logic [1:0]                        reg_read_valid;
    logic [id_pkg::REG_ADDR_WIDTH-1:0] rj;
    logic [id_pkg::REG_ADDR_WIDTH-1:0] rk;
    logic                              use_imm;
    logic [id_pkg::DATA_WIDTH-1:0]     imm;
    logic                              reg_write_valid;
    logic [id_pkg::REG_ADDR_WIDTH-1:0] rd;
    id_pkg::alu_op_e                   aluop;
    id_pkg::alu_sel_e                  alusel;

    modport source (
        output valid, reg_read_valid, rj, rk, use_imm, imm,
        output reg_write_valid, rd, aluop, alusel
    );

    modport sink (
        input valid, reg_read_valid, rj, rk, use_imm, imm,
        input reg_write_valid, rd, aluop, alusel
    );

endinterface

`default_nettype wire

/* common/id_pkg.sv */
`default_nettype none

package id_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int GPR_NUM        = 32;
    localparam int REG_ADDR_WIDTH = $clog2(GPR_NUM);
    localparam int ALU_OP_WIDTH   = 8;
    localparam int ALU_SEL_WIDTH  = 3;

    // major opcode field of each format
    localparam int OPC_3R_WIDTH    = 17;
    localparam int OPC_2RI8_WIDTH  = 14;
    localparam int OPC_2RI12_WIDTH = 10;

    // instr[31:15]
    typedef enum logic [OPC_3R_WIDTH-1:0] {
        ADD_W = 17'h00020,
        SUB_W = 17'h00022,
        SLT   = 17'h00024,
        SLTU  = 17'h00025,
        NOR   = 17'h00028,
        AND   = 17'h00029,
        OR    = 17'h0002a,
        XOR   = 17'h0002b,
        SLL_W = 17'h0002e,
        SRL_W = 17'h0002f,
        SRA_W = 17'h00030
    } opcode_3r_e;

    // instr[31:18], bits 17:15 belong to the immediate field
    typedef enum logic [OPC_2RI8_WIDTH-1:0] {
        SLLI_W = 14'h0010,
        SRLI_W = 14'h0011,
        SRAI_W = 14'h0012
    } opcode_2ri8_e;

    // instr[31:22]
    typedef enum logic [OPC_2RI12_WIDTH-1:0] {
        SLTI   = 10'h008,
        SLTUI  = 10'h009,
        ADDI_W = 10'h00a,
        ANDI   = 10'h00d,
        ORI    = 10'h00e,
        XORI   = 10'h00f
    } opcode_2ri12_e;

    typedef enum logic [ALU_OP_WIDTH-1:0] {
        ALU_NOP  = 8'h00,
        ALU_ADD  = 8'h01,
        ALU_SUB  = 8'h02,
        ALU_SLT  = 8'h03,
        ALU_SLTU = 8'h04,
        ALU_NOR  = 8'h05,
        ALU_AND  = 8'h06,
        ALU_OR   = 8'h07,
        ALU_XOR  = 8'h08,
        ALU_SLL  = 8'h09,
        ALU_SRL  = 8'h0a,
        ALU_SRA  = 8'h0b
    } alu_op_e;

    typedef enum logic [ALU_SEL_WIDTH-1:0] {
        SEL_NONE  = 3'd0,
        SEL_LOGIC = 3'd1,
        SEL_SHIFT = 3'd2,
        SEL_ARITH = 3'd3
    } alu_sel_e;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] pc;
        logic [DATA_WIDTH-1:0] instr;
    } instr_buffer_info_t;

    // result group that execute takes for an alu operation
    function automatic alu_sel_e alu_sel_of(alu_op_e op);
        case (op)
            ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU: return SEL_ARITH;
            ALU_NOR, ALU_AND, ALU_OR, ALU_XOR:   return SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:           return SEL_SHIFT;
            default:                             return SEL_NONE;
        endcase
    endfunction

endpackage

`default_nettype wire

/* decoder/decoder_2ri12.sv */
`default_nettype none

// 2RI12 format {opcode[10], imm[12], rj[5], rd[5]}
module decoder_2ri12 (
    input id_pkg::instr_buffer_info_t info_i,
    decode_result_if.source           result
);

    logic [id_pkg::DATA_WIDTH-1:0] instr;
    id_pkg::opcode_2ri12_e         opcode;
    id_pkg::alu_op_e               aluop;
    logic                          known;
    logic                          sext;
    logic [11:0]                   imm_12;
    logic [id_pkg::DATA_WIDTH-1:0] imm_ext;

    assign instr  = info_i.instr;
    assign opcode = id_pkg::opcode_2ri12_e'(instr[31:22]);
    assign imm_12 = instr[21:10];

    always_comb begin
        known = 1'b1;
        sext  = 1'b1;
        case (opcode)
            id_pkg::SLTI:   aluop = id_pkg::ALU_SLT;
            id_pkg::SLTUI:  aluop = id_pkg::ALU_SLTU;
            id_pkg::ADDI_W: aluop = id_pkg::ALU_ADD;
            // logic ops take ui12
            id_pkg::ANDI: begin
                aluop = id_pkg::ALU_AND;
                sext  = 1'b0;
            end
            id_pkg::ORI: begin
                aluop = id_pkg::ALU_OR;
                sext  = 1'b0;
            end
            id_pkg::XORI: begin
                aluop = id_pkg::ALU_XOR;
                sext  = 1'b0;
            end
            default: begin
                known = 1'b0;
                aluop = id_pkg::ALU_NOP;
            end
        endcase
    end

    assign imm_ext = {{20{sext & imm_12[11]}}, imm_12};

    assign result.valid           = known;
    assign result.reg_read_valid  = known ? 2'b01 : 2'b00;
    assign result.rj              = known ? instr[9:5] : '0;
    assign result.rk              = '0;
    assign result.use_imm         = known;
    assign result.imm             = known ? imm_ext : '0;
    assign result.reg_write_valid = known;
    assign result.rd              = known ? instr[4:0] : '0;
    assign result.aluop           = aluop;
    assign result.alusel          = id_pkg::alu_sel_of(aluop);

endmodule

`default_nettype wire

/* decoder/decoder_2ri8.sv */
`default_nettype none

// 2RI8 format {opcode[14], imm[8], rj[5], rd[5]}
module decoder_2ri8 (
    input id_pkg::instr_buffer_info_t info_i,
    decode_result_if.source           result
);

    logic [id_pkg::DATA_WIDTH-1:0] instr;
    id_pkg::opcode_2ri8_e          opcode;
    id_pkg::alu_op_e               aluop;
    logic                          known;

    assign instr  = info_i.instr;
    assign opcode = id_pkg::opcode_2ri8_e'(instr[31:18]);

    always_comb begin
        known = 1'b1;
        case (opcode)
            id_pkg::SLLI_W: aluop = id_pkg::ALU_SLL;
            id_pkg::SRLI_W: aluop = id_pkg::ALU_SRL;
            id_pkg::SRAI_W: aluop = id_pkg::ALU_SRA;
            default: begin
                known = 1'b0;
                aluop = id_pkg::ALU_NOP;
            end
        endcase
    end

    assign result.valid           = known;
    assign result.reg_read_valid  = known ? 2'b01 : 2'b00;
    assign result.rj              = known ? instr[9:5] : '0;
    assign result.rk              = '0;
    assign result.use_imm         = known;
    // shift amount is only ui5, bits 17:15 ignored
    assign result.imm             = known ? {27'b0, instr[14:10]} : '0;
    assign result.reg_write_valid = known;
    assign result.rd              = known ? instr[4:0] : '0;
    assign result.aluop           = aluop;
    assign result.alusel          = id_pkg::alu_sel_of(aluop);

endmodule

`default_nettype wire

/* decoder/decoder_3r.sv */
`default_nettype none

// 3R format {opcode[17], rk[5], rj[5], rd[5]}
module decoder_3r (
    input id_pkg::instr_buffer_info_t info_i,
    decode_result_if.source           result
);

    logic [id_pkg::DATA_WIDTH-1:0] instr;
    id_pkg::opcode_3r_e            opcode;
    id_pkg::alu_op_e               aluop;
    logic                          known;

    assign instr  = info_i.instr;
    assign opcode = id_pkg::opcode_3r_e'(instr[31:15]);

    always_comb begin
        known = 1'b1;
        case (opcode)
            id_pkg::ADD_W: aluop = id_pkg::ALU_ADD;
            id_pkg::SUB_W: aluop = id_pkg::ALU_SUB;
            id_pkg::SLT:   aluop = id_pkg::ALU_SLT;
            id_pkg::SLTU:  aluop = id_pkg::ALU_SLTU;
            id_pkg::NOR:   aluop = id_pkg::ALU_NOR;
            id_pkg::AND:   aluop = id_pkg::ALU_AND;
            id_pkg::OR:    aluop = id_pkg::ALU_OR;
            id_pkg::XOR:   aluop = id_pkg::ALU_XOR;
            id_pkg::SLL_W: aluop = id_pkg::ALU_SLL;
            id_pkg::SRL_W: aluop = id_pkg::ALU_SRL;
            id_pkg::SRA_W: aluop = id_pkg::ALU_SRA;
            default: begin
                known = 1'b0;
                aluop = id_pkg::ALU_NOP;
            end
        endcase
    end

    // reads rj and rk, writes rd; all zero when not ours
    assign result.valid           = known;
    assign result.reg_read_valid  = known ? 2'b11 : 2'b00;
    assign result.rj              = known ? instr[9:5] : '0;
    assign result.rk              = known ? instr[14:10] : '0;
    assign result.use_imm         = 1'b0;
    assign result.imm             = '0;
    assign result.reg_write_valid = known;
    assign result.rd              = known ? instr[4:0] : '0;
    assign result.aluop           = aluop;
    assign result.alusel          = id_pkg::alu_sel_of(aluop);

endmodule

`default_nettype wire

/* decoder/id_decoder.sv */
`default_nettype none

module id_decoder (
    input  logic                      valid_i,
    input  id_pkg::instr_buffer_info_t info_i,
    decode_result_if.source           result,
    output logic                      illegal_o
);

    decode_result_if res_3r ();
    decode_result_if res_2ri8 ();
    decode_result_if res_2ri12 ();

    logic claimed;

    decoder_3r u_decoder_3r (
        .info_i (info_i),
        .result (res_3r.source)
    );

    decoder_2ri8 u_decoder_2ri8 (
        .info_i (info_i),
        .result (res_2ri8.source)
    );

    decoder_2ri12 u_decoder_2ri12 (
        .info_i (info_i),
        .result (res_2ri12.source)
    );

    // opcode spaces are disjoint and a decoder that misses drives zeros
    assign claimed = res_3r.valid | res_2ri8.valid | res_2ri12.valid;

    assign result.valid           = claimed;
    assign result.reg_read_valid  = res_3r.reg_read_valid | res_2ri8.reg_read_valid
                                  | res_2ri12.reg_read_valid;
    assign result.rj              = res_3r.rj | res_2ri8.rj | res_2ri12.rj;
    assign result.rk              = res_3r.rk | res_2ri8.rk | res_2ri12.rk;
    assign result.use_imm         = res_3r.use_imm | res_2ri8.use_imm | res_2ri12.use_imm;
    assign result.imm             = res_3r.imm | res_2ri8.imm | res_2ri12.imm;
    assign result.reg_write_valid = res_3r.reg_write_valid | res_2ri8.reg_write_valid
                                  | res_2ri12.reg_write_valid;
    assign result.rd              = res_3r.rd | res_2ri8.rd | res_2ri12.rd;
    assign result.aluop  = id_pkg::alu_op_e'(res_3r.aluop | res_2ri8.aluop | res_2ri12.aluop);
    assign result.alusel = id_pkg::alu_sel_e'(res_3r.alusel | res_2ri8.alusel
                                            | res_2ri12.alusel);

    // held instruction that nobody recognizes
    assign illegal_o = valid_i & ~claimed;

endmodule

`default_nettype wire

/* id_stage.f */
+incdir+tb
common/id_pkg.sv
common/decode_result_if.sv
source/id_front.sv
decoder/decoder_3r.sv
decoder/decoder_2ri8.sv
decoder/decoder_2ri12.sv
decoder/id_decoder.sv
source/gpr_file.sv
source/id_issue.sv
source/id_stage.sv
tb/tb_id_stage.sv

/* source/gpr_file.sv */
`default_nettype none

module gpr_file (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic [id_pkg::REG_ADDR_WIDTH-1:0] raddr1_i,
    input  logic [id_pkg::REG_ADDR_WIDTH-1:0] raddr2_i,
    output logic [id_pkg::DATA_WIDTH-1:0]     rdata1_o,
    output logic [id_pkg::DATA_WIDTH-1:0]     rdata2_o,
    input  logic                              we_i,
    input  logic [id_pkg::REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [id_pkg::DATA_WIDTH-1:0]     wdata_i
);

    logic [id_pkg::DATA_WIDTH-1:0] regs [id_pkg::GPR_NUM];

    // r0 is never written, so it stays zero from reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < id_pkg::GPR_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // no bypass, a same-cycle write is seen next cycle
    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

endmodule

`default_nettype wire

/* source/id_front.sv */
`default_nettype none

module id_front (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          instr_valid_i,
    input  logic [id_pkg::DATA_WIDTH-1:0] instr_pc_i,
    input  logic [id_pkg::DATA_WIDTH-1:0] instr_i,
    output logic                          valid_o,
    output id_pkg::instr_buffer_info_t    info_o
);

    // valid level of the held instruction
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= instr_valid_i;
        end
    end

    // pc travels with its instruction so execute sees them aligned
    always_ff @(posedge clk) begin
        info_o.pc    <= instr_pc_i;
        info_o.instr <= instr_i;
    end

endmodule

`default_nettype wire

/* source/id_issue.sv */
`default_nettype none

module id_issue (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              valid_i,
    input  id_pkg::instr_buffer_info_t        info_i,
    decode_result_if.sink                     result,
    input  logic                              illegal_i,
    output logic [id_pkg::REG_ADDR_WIDTH-1:0] raddr1_o,
    output logic [id_pkg::REG_ADDR_WIDTH-1:0] raddr2_o,
    input  logic [id_pkg::DATA_WIDTH-1:0]     rdata1_i,
    input  logic [id_pkg::DATA_WIDTH-1:0]     rdata2_i,
    output logic                              ex_valid_o,
    output logic [id_pkg::DATA_WIDTH-1:0]     ex_pc_o,
    output id_pkg::alu_op_e                   ex_aluop_o,
    output id_pkg::alu_sel_e                  ex_alusel_o,
    output logic [id_pkg::DATA_WIDTH-1:0]     ex_src1_o,
    output logic [id_pkg::DATA_WIDTH-1:0]     ex_src2_o,
    output logic                              ex_rd_we_o,
    output logic [id_pkg::REG_ADDR_WIDTH-1:0] ex_rd_addr_o,
    output logic                              ex_illegal_o
);

    logic [id_pkg::DATA_WIDTH-1:0] src1;
    logic [id_pkg::DATA_WIDTH-1:0] src2;

    assign raddr1_o = result.rj;
    assign raddr2_o = result.rk;

    // unread ports give zero
    assign src1 = result.reg_read_valid[0] ? rdata1_i : '0;

    always_comb begin
        if (result.use_imm) begin
            src2 = result.imm;
        end else if (result.reg_read_valid[1]) begin
            src2 = rdata2_i;
        end else begin
            src2 = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_valid_o   <= 1'b0;
            ex_rd_we_o   <= 1'b0;
            ex_illegal_o <= 1'b0;
        end else begin
            ex_valid_o   <= valid_i;
            ex_rd_we_o   <= valid_i & result.reg_write_valid;
            ex_illegal_o <= illegal_i;
        end
    end

    // aluop and alusel are already NOP/NONE for an unclaimed opcode
    always_ff @(posedge clk) begin
        ex_pc_o      <= info_i.pc;
        ex_aluop_o   <= result.aluop;
        ex_alusel_o  <= result.alusel;
        ex_src1_o    <= src1;
        ex_src2_o    <= src2;
        ex_rd_addr_o <= result.rd;
    end

endmodule

`default_nettype wire

/* source/id_stage.sv */
`default_nettype none

module id_stage (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              instr_valid_i,
    input  logic [id_pkg::DATA_WIDTH-1:0]     instr_pc_i,
    input  logic [id_pkg::DATA_WIDTH-1:0]     instr_i,
    input  logic                              wb_we_i,
    input  logic [id_pkg::REG_ADDR_WIDTH-1:0] wb_addr_i,
    input  logic [id_pkg::DATA_WIDTH-1:0]     wb_data_i,
    output logic                              ex_valid_o,
    output logic [id_pkg::DATA_WIDTH-1:0]     ex_pc_o,
    output id_pkg::alu_op_e                   ex_aluop_o,
    output id_pkg::alu_sel_e                  ex_alusel_o,
    output logic [id_pkg::DATA_WIDTH-1:0]     ex_src1_o,
    output logic [id_pkg::DATA_WIDTH-1:0]     ex_src2_o,
    output logic                              ex_rd_we_o,
    output logic [id_pkg::REG_ADDR_WIDTH-1:0] ex_rd_addr_o,
    output logic                              ex_illegal_o
);

    logic                              front_valid;
    id_pkg::instr_buffer_info_t        front_info;
    logic                              illegal;
    logic [id_pkg::REG_ADDR_WIDTH-1:0] raddr1;
    logic [id_pkg::REG_ADDR_WIDTH-1:0] raddr2;
    logic [id_pkg::DATA_WIDTH-1:0]     rdata1;
    logic [id_pkg::DATA_WIDTH-1:0]     rdata2;

    decode_result_if decoded ();

    id_front u_id_front (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_pc_i    (instr_pc_i),
        .instr_i       (instr_i),
        .valid_o       (front_valid),
        .info_o        (front_info)
    );

    id_decoder u_id_decoder (
        .valid_i   (front_valid),
        .info_i    (front_info),
        .result    (decoded.source),
        .illegal_o (illegal)
    );

    id_issue u_id_issue (
        .clk          (clk),
        .reset_i      (reset_i),
        .valid_i      (front_valid),
        .info_i       (front_info),
        .result       (decoded.sink),
        .illegal_i    (illegal),
        .raddr1_o     (raddr1),
        .raddr2_o     (raddr2),
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .ex_valid_o   (ex_valid_o),
        .ex_pc_o      (ex_pc_o),
        .ex_aluop_o   (ex_aluop_o),
        .ex_alusel_o  (ex_alusel_o),
        .ex_src1_o    (ex_src1_o),
        .ex_src2_o    (ex_src2_o),
        .ex_rd_we_o   (ex_rd_we_o),
        .ex_rd_addr_o (ex_rd_addr_o),
        .ex_illegal_o (ex_illegal_o)
    );

    gpr_file u_gpr_file (
        .clk      (clk),
        .reset_i  (reset_i),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .we_i     (wb_we_i),
        .waddr_i  (wb_addr_i),
        .wdata_i  (wb_data_i)
    );

endmodule

`default_nettype wire

/* tb/id_ref_model.svh */
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// 3R {opcode, rk, rj, rd}
function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rd,
                                       input logic [4:0] rj, input logic [4:0] rk);
    return {op, rk, rj, rd};
endfunction

function automatic logic [31:0] enc_2ri8(input logic [13:0] op, input logic [7:0] imm,
                                         input logic [4:0] rj, input logic [4:0] rd);
    return {op, imm, rj, rd};
endfunction

function automatic logic [31:0] enc_2ri12(input logic [9:0] op, input logic [11:0] imm,
                                          input logic [4:0] rj, input logic [4:0] rd);
    return {op, imm, rj, rd};
endfunction

function automatic id_pkg::alu_sel_e expected_group(input id_pkg::alu_op_e op);
    case (op)
        id_pkg::ALU_NOP:                                  return id_pkg::SEL_NONE;
        id_pkg::ALU_SLL, id_pkg::ALU_SRL, id_pkg::ALU_SRA: return id_pkg::SEL_SHIFT;
        id_pkg::ALU_NOR, id_pkg::ALU_AND, id_pkg::ALU_OR,
        id_pkg::ALU_XOR:                                  return id_pkg::SEL_LOGIC;
        default:                                          return id_pkg::SEL_ARITH;
    endcase
endfunction

// operands come from the shadow copy of the register file
function automatic expect_t expected_bundle(input logic [31:0] pc, input logic [31:0] word);
    expect_t     e;
    logic        is_3r;
    logic        is_2ri8;
    logic [31:0] imm12;
    e       = '0;
    e.pc    = pc;
    e.aluop = id_pkg::ALU_NOP;
    case (word[31:15])
        id_pkg::ADD_W: e.aluop = id_pkg::ALU_ADD;
        id_pkg::SUB_W: e.aluop = id_pkg::ALU_SUB;
        id_pkg::SLT:   e.aluop = id_pkg::ALU_SLT;
        id_pkg::SLTU:  e.aluop = id_pkg::ALU_SLTU;
        id_pkg::NOR:   e.aluop = id_pkg::ALU_NOR;
        id_pkg::AND:   e.aluop = id_pkg::ALU_AND;
        id_pkg::OR:    e.aluop = id_pkg::ALU_OR;
        id_pkg::XOR:   e.aluop = id_pkg::ALU_XOR;
        id_pkg::SLL_W: e.aluop = id_pkg::ALU_SLL;
        id_pkg::SRL_W: e.aluop = id_pkg::ALU_SRL;
        id_pkg::SRA_W: e.aluop = id_pkg::ALU_SRA;
        default: ;
    endcase
    is_3r = (e.aluop != id_pkg::ALU_NOP);
    case (word[31:18])
        id_pkg::SLLI_W: e.aluop = id_pkg::ALU_SLL;
        id_pkg::SRLI_W: e.aluop = id_pkg::ALU_SRL;
        id_pkg::SRAI_W: e.aluop = id_pkg::ALU_SRA;
        default: ;
    endcase
    is_2ri8 = !is_3r && (e.aluop != id_pkg::ALU_NOP);
    case (word[31:22])
        id_pkg::SLTI:   e.aluop = id_pkg::ALU_SLT;
        id_pkg::SLTUI:  e.aluop = id_pkg::ALU_SLTU;
        id_pkg::ADDI_W: e.aluop = id_pkg::ALU_ADD;
        id_pkg::ANDI:   e.aluop = id_pkg::ALU_AND;
        id_pkg::ORI:    e.aluop = id_pkg::ALU_OR;
        id_pkg::XORI:   e.aluop = id_pkg::ALU_XOR;
        default: ;
    endcase
    // logic immediates are unsigned
    if (word[31:22] == id_pkg::ANDI || word[31:22] == id_pkg::ORI
        || word[31:22] == id_pkg::XORI) begin
        imm12 = {20'b0, word[21:10]};
    end else begin
        imm12 = {{20{word[21]}}, word[21:10]};
    end
    e.alusel  = expected_group(e.aluop);
    e.illegal = (e.aluop == id_pkg::ALU_NOP);
    if (!e.illegal) begin
        e.rd_we = 1'b1;
        e.rd    = word[4:0];
        e.src1  = shadow_regs[word[9:5]];
        if (is_3r) begin
            e.src2 = shadow_regs[word[14:10]];
        end else if (is_2ri8) begin
            e.src2 = {27'b0, word[14:10]};
        end else begin
            e.src2 = imm12;
        end
    end
    return e;
endfunction

task automatic compare_field(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    assert (got === want)
    else begin
        errors++;
        $display("error at %0d ns: %s is %h, expected %h", $time, name, got, want);
    end
endtask

task automatic check_bundle(input expect_t e);
    compare_field("ex_valid_o", ex_valid_o, 1'b1);
    compare_field("ex_pc_o", ex_pc_o, e.pc);
    compare_field("ex_aluop_o", ex_aluop_o, e.aluop);
    compare_field("ex_alusel_o", ex_alusel_o, e.alusel);
    compare_field("ex_src1_o", ex_src1_o, e.src1);
    compare_field("ex_src2_o", ex_src2_o, e.src2);
    compare_field("ex_rd_we_o", ex_rd_we_o, e.rd_we);
    compare_field("ex_rd_addr_o", ex_rd_addr_o, e.rd);
    compare_field("ex_illegal_o", ex_illegal_o, e.illegal);
endtask

// nothing due, so the bundle must stay quiet
task automatic check_idle();
    compare_field("ex_valid_o", ex_valid_o, 1'b0);
    compare_field("ex_rd_we_o", ex_rd_we_o, 1'b0);
    compare_field("ex_illegal_o", ex_illegal_o, 1'b0);
endtask

`endif

/* tb/tb_id_stage.sv */
`default_nettype none

module tb_id_stage;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DRAIN_LIMIT  = 50;
    localparam int RANDOM_COUNT = 200;

    // one expected ex_ bundle, due at a given falling edge
    typedef struct packed {
        logic [31:0]      due;
        logic [31:0]      pc;
        id_pkg::alu_op_e  aluop;
        id_pkg::alu_sel_e alusel;
        logic [31:0]      src1;
        logic [31:0]      src2;
        logic             rd_we;
        logic [4:0]       rd;
        logic             illegal;
    } expect_t;

    logic                              clk;
    logic                              reset_i;
    logic                              instr_valid_i;
    logic [id_pkg::DATA_WIDTH-1:0]     instr_pc_i;
    logic [id_pkg::DATA_WIDTH-1:0]     instr_i;
    logic                              wb_we_i;
    logic [id_pkg::REG_ADDR_WIDTH-1:0] wb_addr_i;
    logic [id_pkg::DATA_WIDTH-1:0]     wb_data_i;
    logic                              ex_valid_o;
    logic [id_pkg::DATA_WIDTH-1:0]     ex_pc_o;
    id_pkg::alu_op_e                   ex_aluop_o;
    id_pkg::alu_sel_e                  ex_alusel_o;
    logic [id_pkg::DATA_WIDTH-1:0]     ex_src1_o;
    logic [id_pkg::DATA_WIDTH-1:0]     ex_src2_o;
    logic                              ex_rd_we_o;
    logic [id_pkg::REG_ADDR_WIDTH-1:0] ex_rd_addr_o;
    logic                              ex_illegal_o;

    expect_t     expected_q[$];
    expect_t     head;
    logic [31:0] shadow_regs [32];
    logic [31:0] cyc;
    logic [31:0] next_pc;
    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          tests_passed;
    int          tests_failed;
    int          err_mark;
    int          check_mark;

    logic [16:0] ops_3r [11] = '{
        id_pkg::ADD_W, id_pkg::SUB_W, id_pkg::SLT, id_pkg::SLTU, id_pkg::NOR, id_pkg::AND,
        id_pkg::OR, id_pkg::XOR, id_pkg::SLL_W, id_pkg::SRL_W, id_pkg::SRA_W
    };
    logic [13:0] ops_2ri8 [3] = '{id_pkg::SLLI_W, id_pkg::SRLI_W, id_pkg::SRAI_W};
    logic [9:0]  ops_2ri12 [6] = '{
        id_pkg::SLTI, id_pkg::SLTUI, id_pkg::ADDI_W, id_pkg::ANDI, id_pkg::ORI, id_pkg::XORI
    };

    id_stage DUT (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_pc_i    (instr_pc_i),
        .instr_i       (instr_i),
        .wb_we_i       (wb_we_i),
        .wb_addr_i     (wb_addr_i),
        .wb_data_i     (wb_data_i),
        .ex_valid_o    (ex_valid_o),
        .ex_pc_o       (ex_pc_o),
        .ex_aluop_o    (ex_aluop_o),
        .ex_alusel_o   (ex_alusel_o),
        .ex_src1_o     (ex_src1_o),
        .ex_src2_o     (ex_src2_o),
        .ex_rd_we_o    (ex_rd_we_o),
        .ex_rd_addr_o  (ex_rd_addr_o),
        .ex_illegal_o  (ex_illegal_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!reset_i) begin
            if (expected_q.size() != 0 && expected_q[0].due == cyc) begin
                head = expected_q.pop_front();
                check_bundle(head);
            end else begin
                check_idle();
            end
        end
        cyc = cyc + 1;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper LCG bits pick the format, the rest of the word is random
    function automatic logic [31:0] random_instr();
        logic [31:0] sel;
        logic [31:0] body;
        sel  = next_rand();
        body = next_rand();
        case (sel[31:30])
            2'd0:    return {ops_3r[sel[29:24] % 11], body[14:0]};
            2'd1:    return {ops_2ri8[sel[29:24] % 3], body[17:0]};
            2'd2:    return {ops_2ri12[sel[29:24] % 6], body[21:0]};
            default: return body;
        endcase
    endfunction

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        wb_we_i   <= 1'b1;
        wb_addr_i <= addr;
        wb_data_i <= data;
        @(posedge clk);
        wb_we_i <= 1'b0;
        // r0 ignores writes
        if (addr != 5'd0) begin
            shadow_regs[addr] = data;
        end
    endtask

    task automatic issue_instr(input logic [31:0] word);
        expect_t e;
        @(posedge clk);
        instr_valid_i <= 1'b1;
        instr_pc_i    <= next_pc;
        instr_i       <= word;
        e     = expected_bundle(next_pc, word);
        e.due = cyc + 2;
        expected_q.push_back(e);
        next_pc = next_pc + 4;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("timeout: %0d results never appeared on the ex_ outputs",
                     expected_q.size());
            $display("Test FAILED");
            $finish;
        end else begin
            // a few idle cycles catch a duplicated result
            repeat (3) @(posedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        instr_valid_i <= 1'b0;
        instr_i       <= '0;
        wait_drained();
        if (errors == err_mark) begin
            tests_passed++;
            $display("%s: passed, %0d checks", name, checks - check_mark);
        end else begin
            tests_failed++;
            $display("%s: failed, %0d errors", name, errors - err_mark);
        end
        err_mark   = errors;
        check_mark = checks;
    endtask

    initial begin
        errors        = 0;
        checks        = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        err_mark      = 0;
        check_mark    = 0;
        cyc           = '0;
        next_pc       = 32'h1c00_0000;
        lcg_state     = 32'd17508;
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_pc_i    = '0;
        instr_i       = '0;
        wb_we_i       = 1'b0;
        wb_addr_i     = '0;
        wb_data_i     = '0;
        for (int i = 0; i < 32; i++) begin
            shadow_regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;

        repeat (6) @(posedge clk);
        finish_test("reset");

        write_reg(5'd0, 32'hdead_beef);
        for (int a = 1; a < 32; a++) begin
            write_reg(5'(a), (32'(a) * 32'h9e37_79b9) ^ (32'(a) << 27));
        end
        for (int i = 0; i < 11; i++) begin
            issue_instr(enc_3r(ops_3r[i], 5'(i + 1), 5'(i + 7), 5'(31 - i)));
        end
        issue_instr(enc_3r(id_pkg::ADD_W, 5'd9, 5'd0, 5'd4));
        issue_instr(enc_3r(id_pkg::XOR, 5'd10, 5'd12, 5'd0));
        finish_test("3r register ops");

        // bits 17:15 set on purpose
        for (int i = 0; i < 3; i++) begin
            issue_instr(enc_2ri8(ops_2ri8[i], {3'b111, 5'(i * 13)}, 5'(i + 3), 5'(i + 20)));
            issue_instr(enc_2ri8(ops_2ri8[i], 8'h1f, 5'(i + 28), 5'(i + 1)));
        end
        finish_test("shift immediates");

        for (int i = 0; i < 6; i++) begin
            issue_instr(enc_2ri12(ops_2ri12[i], 12'h800, 5'(i + 2), 5'(i + 10)));
            issue_instr(enc_2ri12(ops_2ri12[i], 12'hfff, 5'(i + 14), 5'(i + 4)));
            issue_instr(enc_2ri12(ops_2ri12[i], 12'h7ff, 5'(i), 5'(i + 25)));
        end
        finish_test("12-bit immediates");

        issue_instr(32'h0000_0000);
        issue_instr(32'hffff_ffff);
        issue_instr({17'h00021, 15'h1234});
        issue_instr({10'h00b, 22'h2a5a5});
        issue_instr({14'h0013, 18'h3ffff});
        finish_test("illegal opcodes");

        for (int n = 0; n < RANDOM_COUNT; n++) begin
            issue_instr(random_instr());
        end
        finish_test("random stream");

        $display("tests %0d passed, %0d failed, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

`include "id_ref_model.svh"

endmodule

`default_nettype wire
